// ==== all.f ====
+incdir+.
mlp_pkg.sv
mlp_input_layer.sv
mlp_hidden_neuron.sv
mlp_output_stage.sv
mlp_top.sv
tb_mlp.sv

// ==== Makefile ====
TOP = tb_mlp

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) \
		-f all.f --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_mlp.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mlp_cfg.svh"

module tb_mlp;

    localparam int RESET_CYCLES    = 5;
    localparam int LATENCY         = 4;
    localparam int ACK_LIMIT       = 8;
    localparam int N_TABLE         = 12;
    localparam int N_RANDOM        = 20;
    localparam int N_B2B           = 4;
    localparam int N_SAMPLES       = N_TABLE + N_RANDOM + N_B2B;
    localparam int WATCHDOG_CYCLES = N_SAMPLES * 10 + 50;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [15:0] wb_dat_i;
    logic [15:0] wb_dat_o;
    logic        wb_ack;
    logic        result_valid;
    logic [15:0] sig_value;
    logic        class_out;

    logic [15:0] tab_x1 [N_TABLE];
    logic [15:0] tab_x2 [N_TABLE];
    logic [15:0] tab_sig [N_TABLE];
    logic        tab_cls [N_TABLE];

    logic [15:0] exp_sig_q [$];
    logic        exp_cls_q [$];
    int          exp_due_q [$];

    int          cycle;
    int          ack_cycle;
    int          errors;
    int          checks;
    int          launches;
    integer      seed;
    logic        ack_prev;

    mlp_top DUT (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack       (wb_ack),
        .result_valid (result_valid),
        .sig_value    (sig_value),
        .class_out    (class_out)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    // -1 weight as 16-bit complement
    function automatic logic [15:0] weigh(input logic [15:0] v, input logic neg);
        return neg ? (16'hFFFF - v) : v;
    endfunction

    function automatic logic [15:0] relu(input logic [15:0] v);
        return v[15] ? 16'h0000 : v;
    endfunction

    function automatic logic [7:0] l2_mask(input int n);
        case (n)
            0:       return `MLP_L2_NEG_1;
            1:       return `MLP_L2_NEG_2;
            2:       return `MLP_L2_NEG_3;
            3:       return `MLP_L2_NEG_4;
            4:       return `MLP_L2_NEG_5;
            5:       return `MLP_L2_NEG_6;
            6:       return `MLP_L2_NEG_7;
            7:       return `MLP_L2_NEG_8;
            8:       return `MLP_L2_NEG_9;
            9:       return `MLP_L2_NEG_10;
            10:      return `MLP_L2_NEG_11;
            default: return `MLP_L2_NEG_12;
        endcase
    endfunction

    function automatic void model_sample(input logic [15:0] a, input logic [15:0] b,
                                         output logic [15:0] sig, output logic cls);
        logic [15:0] y [8];
        logic [15:0] acc;
        logic [15:0] s;
        logic [7:0]  neg_a;
        logic [7:0]  neg_b;
        logic [7:0]  m;
        neg_a = `MLP_L1_NEG_X1;
        neg_b = `MLP_L1_NEG_X2;
        for (int i = 0; i < 8; i++)
            y[i] = relu(weigh(a, neg_a[i]) + weigh(b, neg_b[i]));
        s = 16'h0000;
        for (int n = 0; n < 12; n++)
        begin
            m   = l2_mask(n);
            acc = 16'h0000;
            for (int j = 0; j < 8; j++)
                acc = acc + weigh(y[j], m[j]);
            s = s + relu(acc);
        end
        if (s < `MLP_SIG_BP1)
            sig = (s >> 2) + `MLP_SIG_OFS0;
        else if (s < `MLP_SIG_BP2)
            sig = (s >> 3) + `MLP_SIG_OFS1;
        else if (s < `MLP_SIG_BP3)
            sig = (s >> 5) + `MLP_SIG_OFS2;
        else
            sig = `MLP_SIG_ONE;
        cls = sig > `MLP_CLASS_THRESH;
    endfunction

    task automatic fill_table();
        // Zero, then sums 670, 2070, 3470, 6970, exact 2432 and 5120
        tab_x1 = '{16'h0000, 16'd100, 16'd300, 16'd500, 16'd1000, 16'h0000,
                   16'h0000, 16'd5000, 16'h0000, 16'hFF00, 16'h1234, 16'h8001};
        // Entries 7 and 8 give sums with bit 15 set
        tab_x2 = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'd205,
                   16'd429, 16'h0000, 16'd3001, 16'hFF00, 16'h0ABC, 16'h7FFF};
        for (int i = 0; i < N_TABLE; i++)
            model_sample(tab_x1[i], tab_x2[i], tab_sig[i], tab_cls[i]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone master
    ////////////////////////////////////////////////////////////////////////////
    task automatic wait_ack();
        int n;
        n = 0;
        @(negedge clk);
        while (!wb_ack && n < ACK_LIMIT)
        begin
            n++;
            @(negedge clk);
        end
        if (!wb_ack)
        begin
            errors++;
            $display("The slave gave no ack within %0d cycles at cycle %0d", ACK_LIMIT, cycle);
        end
        ack_cycle = cycle;
    endtask

    task automatic bus_write(input logic [1:0] adr, input logic [15:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_i <= data;
        wait_ack();
    endtask

    task automatic bus_read(input logic [1:0] adr, output logic [15:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack();
        data = wb_dat_o;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic launch_sample(input logic [15:0] x2, input logic [15:0] sig, input logic cls);
        bus_write(mlp_pkg::REG_X2_GO, x2);
        exp_sig_q.push_back(sig);
        exp_cls_q.push_back(cls);
        exp_due_q.push_back(ack_cycle + LATENCY);
        launches++;
    endtask

    task automatic wait_results();
        while (exp_due_q.size() > 0)
            @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Result and handshake monitor
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (wb_ack && ack_prev)
            begin
                errors++;
                $display("wb_ack stayed high for more than one cycle at cycle %0d", cycle);
            end
            ack_prev = wb_ack;
            if (exp_due_q.size() > 0 && cycle > exp_due_q[0])
            begin
                errors++;
                $display("No result_valid for the launch due at cycle %0d", exp_due_q[0]);
                void'(exp_sig_q.pop_front());
                void'(exp_cls_q.pop_front());
                void'(exp_due_q.pop_front());
            end
            if (result_valid && exp_due_q.size() == 0)
            begin
                errors++;
                $display("result_valid rose at cycle %0d with no sample in flight", cycle);
            end
            else if (result_valid)
            begin
                checks++;
                if (cycle != exp_due_q[0])
                begin
                    errors++;
                    $display("result_valid came at cycle %0d instead of %0d", cycle, exp_due_q[0]);
                end
                if (sig_value !== exp_sig_q[0])
                begin
                    errors++;
                    $display("error sig_value: expected 0x%h, got 0x%h", exp_sig_q[0], sig_value);
                end
                if (class_out !== exp_cls_q[0])
                begin
                    errors++;
                    $display("error class_out: expected 0x%h, got 0x%h", exp_cls_q[0], class_out);
                end
                void'(exp_sig_q.pop_front());
                void'(exp_cls_q.pop_front());
                void'(exp_due_q.pop_front());
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run stopped by watchdog after %0d cycles, errors: %0d", cycle, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        logic [15:0] rd;
        logic [15:0] x1;
        logic [15:0] x2;
        logic [15:0] sig;
        logic        cls;
        integer      rnd;
        int          last_ack;
        clk       = 1'b0;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = 2'd0;
        wb_dat_i  = 16'h0000;
        cycle     = 0;
        errors    = 0;
        checks    = 0;
        launches  = 0;
        ack_prev  = 1'b0;
        seed      = 32'hb17b475b;
        fill_table();

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checks++;
        if (result_valid !== 1'b0)
        begin
            errors++;
            $display("error result_valid: expected 0x0, got 0x%h", result_valid);
        end
        checks++;
        if (class_out !== 1'b0)
        begin
            errors++;
            $display("error class_out: expected 0x0, got 0x%h", class_out);
        end
        checks++;
        if (sig_value !== 16'h0000)
        begin
            errors++;
            $display("error sig_value: expected 0x0000, got 0x%h", sig_value);
        end
        bus_read(mlp_pkg::REG_STATUS, rd);
        checks++;
        if (rd !== 16'h0000)
        begin
            errors++;
            $display("error wb_dat_o: expected 0x0000, got 0x%h", rd);
        end

        // x1 alone must not launch
        bus_write(mlp_pkg::REG_X1, 16'h00AA);
        bus_idle();
        repeat (8) @(negedge clk);

        for (int i = 0; i < N_TABLE; i++)
        begin
            bus_write(mlp_pkg::REG_X1, tab_x1[i]);
            launch_sample(tab_x2[i], tab_sig[i], tab_cls[i]);
        end
        bus_idle();
        wait_results();

        for (int i = 0; i < N_RANDOM; i++)
        begin
            rnd = $random(seed);
            x1  = rnd[15:0];
            rnd = $random(seed);
            x2  = rnd[15:0];
            model_sample(x1, x2, sig, cls);
            bus_write(mlp_pkg::REG_X1, x1);
            launch_sample(x2, sig, cls);
        end
        bus_idle();
        wait_results();

        // Back-to-back launches with a shared x1
        x1 = 16'd180;
        bus_write(mlp_pkg::REG_X1, x1);
        last_ack = ack_cycle;
        for (int i = 0; i < N_B2B; i++)
        begin
            x2 = 16'd40 * i[15:0];
            model_sample(x1, x2, sig, cls);
            launch_sample(x2, sig, cls);
            if (ack_cycle - last_ack != 2)
            begin
                errors++;
                $display("Launch %0d came %0d cycles after the previous access", i,
                         ack_cycle - last_ack);
            end
            last_ack = ack_cycle;
        end
        bus_idle();
        wait_results();

        bus_read(mlp_pkg::REG_STATUS, rd);
        bus_idle();
        checks++;
        if (rd !== {8'h00, launches[7:0]})
        begin
            errors++;
            $display("error wb_dat_o: expected 0x%h, got 0x%h", {8'h00, launches[7:0]}, rd);
        end

        $display("Checks: %0d, launches: %0d, errors: %0d", checks, launches, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mlp_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mlp_cfg.svh"

module mlp_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`MLP_ADR_W-1:0] wb_adr,
    input  mlp_pkg::word_t        wb_dat_i,
    output mlp_pkg::word_t        wb_dat_o,
    output logic                  wb_ack,
    output logic                  result_valid,
    output mlp_pkg::word_t        sig_value,
    output logic                  class_out
);

    // Neuron 1 mask sits in the low byte
    localparam logic [`MLP_N_L2*`MLP_N_L1-1:0] L2_MASKS = {
        `MLP_L2_NEG_12, `MLP_L2_NEG_11, `MLP_L2_NEG_10, `MLP_L2_NEG_9,
        `MLP_L2_NEG_8,  `MLP_L2_NEG_7,  `MLP_L2_NEG_6,  `MLP_L2_NEG_5,
        `MLP_L2_NEG_4,  `MLP_L2_NEG_3,  `MLP_L2_NEG_2,  `MLP_L2_NEG_1
    };

    logic           l1_valid;
    mlp_pkg::word_t l1_y [`MLP_N_L1];
    logic           l2_valid;
    mlp_pkg::word_t l2_n [`MLP_N_L2];

    mlp_input_layer u_input_layer (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .l1_valid (l1_valid),
        .l1_y     (l1_y)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Hidden layer 2
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < `MLP_N_L2; i++)
    begin : g_l2
        if (i == 0)
        begin : g_lead
            mlp_hidden_neuron #(
                .NEG_MASK (L2_MASKS[i*`MLP_N_L1 +: `MLP_N_L1])
            ) u_neuron (
                .clk       (clk),
                .rst       (rst),
                .in_valid  (l1_valid),
                .in_y      (l1_y),
                .out_valid (l2_valid),
                .out_n     (l2_n[i])
            );
        end
        else
        begin : g_rest
            // Same valid timing as neuron 0
            mlp_hidden_neuron #(
                .NEG_MASK (L2_MASKS[i*`MLP_N_L1 +: `MLP_N_L1])
            ) u_neuron (
                .clk       (clk),
                .rst       (rst),
                .in_valid  (l1_valid),
                .in_y      (l1_y),
                .out_valid (),
                .out_n     (l2_n[i])
            );
        end
    end

    mlp_output_stage u_output_stage (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (l2_valid),
        .in_n         (l2_n),
        .result_valid (result_valid),
        .sig_value    (sig_value),
        .class_out    (class_out)
    );

endmodule

`default_nettype wire

// ==== mlp_output_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mlp_cfg.svh"

module mlp_output_stage (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  mlp_pkg::word_t in_n [`MLP_N_L2],
    output logic           result_valid,
    output mlp_pkg::word_t sig_value,
    output logic           class_out
);

    mlp_pkg::word_t    sum;
    mlp_pkg::sig_seg_e seg;
    mlp_pkg::word_t    s_q;
    mlp_pkg::sig_seg_e seg_q;
    logic              v1_q;
    mlp_pkg::word_t    sig_next;

    ////////////////////////////////////////////////////////////////////////////
    // Output neuron sum and segment select
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        sum = '0;
        for (int k = 0; k < `MLP_N_L2; k++)
        begin
            sum = sum + in_n[k];
        end
    end

    // Unsigned compare, so bit 15 set lands in the top segment
    always_comb
    begin
        if (sum < `MLP_SIG_BP1)
            seg = mlp_pkg::SEG_SHR2;
        else if (sum < `MLP_SIG_BP2)
            seg = mlp_pkg::SEG_SHR3;
        else if (sum < `MLP_SIG_BP3)
            seg = mlp_pkg::SEG_SHR5;
        else
            seg = mlp_pkg::SEG_ONE;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            v1_q <= 1'b0;
        else
            v1_q <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            s_q   <= sum;
            seg_q <= seg;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Piecewise-linear sigmoid and decision
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (seg_q)
            mlp_pkg::SEG_SHR2: sig_next = (s_q >> 2) + `MLP_SIG_OFS0;
            mlp_pkg::SEG_SHR3: sig_next = (s_q >> 3) + `MLP_SIG_OFS1;
            mlp_pkg::SEG_SHR5: sig_next = (s_q >> 5) + `MLP_SIG_OFS2;
            default:           sig_next = `MLP_SIG_ONE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            result_valid <= 1'b0;
            sig_value    <= '0;
            class_out    <= 1'b0;
        end
        else
        begin
            result_valid <= v1_q;
            if (v1_q)
            begin
                sig_value <= sig_next;
                class_out <= sig_next > `MLP_CLASS_THRESH;
            end
        end
    end

endmodule

`default_nettype wire

// ==== mlp_hidden_neuron.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mlp_cfg.svh"

module mlp_hidden_neuron #(
    parameter logic [`MLP_N_L1-1:0] NEG_MASK = '0
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  mlp_pkg::word_t in_y [`MLP_N_L1],
    output logic           out_valid,
    output mlp_pkg::word_t out_n
);

    mlp_pkg::word_t acc;

    // A -1 weight is the complement of the input
    always_comb
    begin
        acc = '0;
        for (int j = 0; j < `MLP_N_L1; j++)
        begin
            acc = acc + (NEG_MASK[j] ? ~in_y[j] : in_y[j]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    // ReLU, negative sums become zero
    always_ff @(posedge clk)
    begin
        if (in_valid)
            out_n <= acc[`MLP_DATA_W-1] ? '0 : acc;
    end

endmodule

`default_nettype wire

// ==== mlp_input_layer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mlp_cfg.svh"

module mlp_input_layer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`MLP_ADR_W-1:0] wb_adr,
    input  mlp_pkg::word_t        wb_dat_i,
    output mlp_pkg::word_t        wb_dat_o,
    output logic                  wb_ack,
    output logic                  l1_valid,
    output mlp_pkg::word_t        l1_y [`MLP_N_L1]
);

    localparam logic [`MLP_N_L1-1:0] NEG_X1 = `MLP_L1_NEG_X1;
    localparam logic [`MLP_N_L1-1:0] NEG_X2 = `MLP_L1_NEG_X2;

    mlp_pkg::word_t        x_q [`MLP_N_IN];
    mlp_pkg::word_t        l1_sum [`MLP_N_L1];
    logic [`MLP_CNT_W-1:0] launch_cnt;
    logic                  launch;
    logic                  access;

    // New access, ack goes high on the next edge
    assign access = wb_cyc && wb_stb && !wb_ack;

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone slave
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_ack     <= 1'b0;
            wb_dat_o   <= '0;
            launch     <= 1'b0;
            launch_cnt <= '0;
            for (int i = 0; i < `MLP_N_IN; i++)
            begin
                x_q[i] <= '0;
            end
        end
        else
        begin
            wb_ack <= access;
            launch <= 1'b0;
            if (access && wb_we)
            begin
                case (mlp_pkg::wb_reg_e'(wb_adr))
                    mlp_pkg::REG_X1:
                        x_q[0] <= wb_dat_i;
                    mlp_pkg::REG_X2_GO:
                    begin
                        x_q[1]     <= wb_dat_i;
                        launch     <= 1'b1;
                        launch_cnt <= launch_cnt + 1'b1;
                    end
                    default: ;
                endcase
            end
            else if (access)
            begin
                case (mlp_pkg::wb_reg_e'(wb_adr))
                    mlp_pkg::REG_X1:     wb_dat_o <= x_q[0];
                    mlp_pkg::REG_X2_GO:  wb_dat_o <= x_q[1];
                    mlp_pkg::REG_STATUS: wb_dat_o <= mlp_pkg::word_t'(launch_cnt);
                    default:             wb_dat_o <= '0;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Hidden layer 1
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        for (int i = 0; i < `MLP_N_L1; i++)
        begin
            l1_sum[i] = (NEG_X1[i] ? ~x_q[0] : x_q[0])
                      + (NEG_X2[i] ? ~x_q[1] : x_q[1]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            l1_valid <= 1'b0;
        else
            l1_valid <= launch;
    end

    // ReLU on the way into the register
    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            for (int i = 0; i < `MLP_N_L1; i++)
            begin
                l1_y[i] <= l1_sum[i][`MLP_DATA_W-1] ? '0 : l1_sum[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== mlp_pkg.sv ====
`default_nettype none

`include "mlp_cfg.svh"

package mlp_pkg;

    // One data word, all adds wrap at this width
    typedef logic [`MLP_DATA_W-1:0] word_t;

    // Sigmoid segment, picked from the output neuron sum
    typedef enum logic [1:0] {
        SEG_SHR2,
        SEG_SHR3,
        SEG_SHR5,
        SEG_ONE
    } sig_seg_e;

    // Wishbone register addresses
    typedef enum logic [`MLP_ADR_W-1:0] {
        REG_X1     = `MLP_REG_X1,
        REG_X2_GO  = `MLP_REG_X2_GO,
        REG_STATUS = `MLP_REG_STATUS
    } wb_reg_e;

endpackage

`default_nettype wire

// ==== mlp_cfg.svh ====
`ifndef MLP_CFG_SVH
`define MLP_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Data path sizes
////////////////////////////////////////////////////////////////////////////
`define MLP_DATA_W        16
`define MLP_N_IN          2
`define MLP_N_L1          8
`define MLP_N_L2          12

// Wishbone register map
`define MLP_ADR_W         2
`define MLP_REG_X1        2'd0
`define MLP_REG_X2_GO     2'd1
`define MLP_REG_STATUS    2'd2
`define MLP_CNT_W         8

////////////////////////////////////////////////////////////////////////////
// Weight signs, bit n set means input n is complemented
////////////////////////////////////////////////////////////////////////////
`define MLP_L1_NEG_X1     8'hFB
`define MLP_L1_NEG_X2     8'h27

`define MLP_L2_NEG_1      8'h9A
`define MLP_L2_NEG_2      8'h2E
`define MLP_L2_NEG_3      8'hDA
`define MLP_L2_NEG_4      8'h0E
`define MLP_L2_NEG_5      8'hD0
`define MLP_L2_NEG_6      8'h71
`define MLP_L2_NEG_7      8'h6D
`define MLP_L2_NEG_8      8'h07
`define MLP_L2_NEG_9      8'h30
`define MLP_L2_NEG_10     8'hD0
`define MLP_L2_NEG_11     8'h36
`define MLP_L2_NEG_12     8'h18

// Sigmoid breakpoints and offsets
`define MLP_SIG_BP1       16'd1024
`define MLP_SIG_BP2       16'd2432
`define MLP_SIG_BP3       16'd5120
`define MLP_SIG_OFS0      16'd512
`define MLP_SIG_OFS1      16'd640
`define MLP_SIG_OFS2      16'd864
`define MLP_SIG_ONE       16'd1024
`define MLP_CLASS_THRESH  16'd512

`endif
